/* design/reflex_pkg.sv */
package reflex_pkg;

    //////////////////////////////////////////////////
    // datapath sizes
    //////////////////////////////////////////////////
    localparam int WAVE_AW    = 8;
    localparam int WAVE_DW    = 16;
    localparam int WAVE_DEPTH = 1 << WAVE_AW;
    localparam int PARAM_W    = 32;
    localparam int CNT_W      = 32;
    localparam int HOST_W     = 16;
    // membrane and drive keep the full product width
    localparam int MEM_W      = 2 * PARAM_W;

    // host control word bits
    localparam int CTRL_RESET_GLOBAL = 0;
    localparam int CTRL_SIM_RESET    = 1;

    // trigger-in bit indices
    localparam int TRIG_GAIN     = 3;
    localparam int TRIG_THRESH   = 4;
    localparam int TRIG_LEN_OFS  = 5;
    localparam int TRIG_HALF_CNT = 7;

    // power-up parameter values
    localparam logic [HOST_W-1:0]  RST_HALF_CNT = 16'd3;
    localparam logic [PARAM_W-1:0] RST_GAIN     = 32'd256;
    localparam logic [PARAM_W-1:0] RST_THRESH   = 32'd65536;
    localparam logic [PARAM_W-1:0] RST_LEN_OFS  = 32'd40000;

    // drive = (len * gain) >> GAIN_SHIFT
    localparam int GAIN_SHIFT = 8;

    // activity led stretch, in ticks
    localparam int ACT_TICKS = 16;
    localparam int ACT_W     = 5;

    typedef enum logic [1:0] {ARB_IDLE, ARB_WRITE, ARB_READ} arb_state_t;

    typedef enum logic [1:0] {PLAY_WAIT, PLAY_REQ, PLAY_DATA} play_state_t;

endpackage

/* design/param_bank.sv */
`timescale 1ns/1ps

module param_bank (
    input  logic                           ep50trig,
    input  logic                           reset_global,
    input  logic [reflex_pkg::HOST_W-1:0]  i_trig,
    input  logic [reflex_pkg::HOST_W-1:0]  i_data_lo,
    input  logic [reflex_pkg::HOST_W-1:0]  i_data_hi,
    output logic [reflex_pkg::HOST_W-1:0]  o_half_cnt,
    output logic [reflex_pkg::PARAM_W-1:0] o_gain,
    output logic [reflex_pkg::PARAM_W-1:0] o_thresh,
    output logic [reflex_pkg::PARAM_W-1:0] o_len_ofs
);
    import reflex_pkg::*;

    logic [PARAM_W-1:0] host_word;

    // both wire-ins form one 32-bit value
    assign host_word = {i_data_hi, i_data_lo};

    // tick period only needs the low word
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            o_half_cnt <= RST_HALF_CNT;
        else if (i_trig[TRIG_HALF_CNT])
            o_half_cnt <= i_data_lo;
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            o_gain <= RST_GAIN;
        else if (i_trig[TRIG_GAIN])
            o_gain <= host_word;
    end

    // firing threshold of the motoneuron
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            o_thresh <= RST_THRESH;
        else if (i_trig[TRIG_THRESH])
            o_thresh <= host_word;
    end

    // muscle rest length, position is subtracted from it
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            o_len_ofs <= RST_LEN_OFS;
        else if (i_trig[TRIG_LEN_OFS])
            o_len_ofs <= host_word;
    end

endmodule

/* design/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen (
    input  logic                          ep50trig,
    input  logic                          reset_global,
    input  logic                          i_sim_reset,
    input  logic [reflex_pkg::HOST_W-1:0] i_half_cnt,
    output logic                          o_tick
);
    import reflex_pkg::*;

    logic [HOST_W-1:0] down_cnt;

    // counts half_cnt down to zero, so one tick every half_cnt+1 cycles
    // the period is only reloaded at terminal count
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
        begin
            down_cnt <= i_half_cnt;
            o_tick   <= 1'b0;
        end
        else if (down_cnt == '0)
        begin
            down_cnt <= i_half_cnt;
            o_tick   <= 1'b1;
        end
        else
        begin
            down_cnt <= down_cnt - 1'b1;
            o_tick   <= 1'b0;
        end
    end

endmodule

/* design/wave_loader.sv */
`timescale 1ns/1ps

module wave_loader (
    input  logic                             ep50trig,
    input  logic                             reset_global,
    input  logic                             i_sim_reset,
    input  logic                             i_pipe_write,
    input  logic [reflex_pkg::WAVE_DW-1:0]   i_pipe_data,
    output logic                             o_wr_req,
    output logic [reflex_pkg::WAVE_AW-1:0]   o_wr_addr,
    output logic [reflex_pkg::WAVE_DW-1:0]   o_wr_data,
    output logic [reflex_pkg::WAVE_AW:0]     o_wave_len
);
    import reflex_pkg::*;

    // one bit wider than the address so that a full memory reads 256
    logic [WAVE_AW:0] wr_count;
    logic             full;

    assign full = (wr_count == (WAVE_AW+1)'(WAVE_DEPTH));

    // pipe words beyond the memory size are dropped
    assign o_wr_req   = i_pipe_write && !full;
    assign o_wr_addr  = wr_count[WAVE_AW-1:0];
    assign o_wr_data  = i_pipe_data;
    assign o_wave_len = wr_count;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
            wr_count <= '0;
        else if (o_wr_req)
            wr_count <= wr_count + 1'b1;
    end

endmodule

/* design/wave_store.sv */
`timescale 1ns/1ps

module wave_store (
    input  logic                           ep50trig,
    input  logic                           reset_global,
    input  logic                           i_wr_req,
    input  logic [reflex_pkg::WAVE_AW-1:0] i_wr_addr,
    input  logic [reflex_pkg::WAVE_DW-1:0] i_wr_data,
    input  logic                           i_rd_req,
    input  logic [reflex_pkg::WAVE_AW-1:0] i_rd_addr,
    output logic                           o_rd_grant,
    output logic                           o_rd_valid,
    output logic [reflex_pkg::WAVE_DW-1:0] o_rd_data
);
    import reflex_pkg::*;

    logic [WAVE_DW-1:0] wave_mem [0:WAVE_DEPTH-1];

    arb_state_t arb_state;
    arb_state_t arb_next;

    //////////////////////////////////////////////////
    // fixed-priority arbiter
    //////////////////////////////////////////////////

    // the host pipe can't be stalled, so a write always owns the port
    always_comb
    begin
        if (i_wr_req)
            arb_next = ARB_WRITE;
        else if (i_rd_req)
            arb_next = ARB_READ;
        else
            arb_next = ARB_IDLE;
    end

    assign o_rd_grant = (arb_next == ARB_READ);

    // remembers who used the port last cycle
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            arb_state <= ARB_IDLE;
        else
            arb_state <= arb_next;
    end

    // read data lands one cycle after its grant
    assign o_rd_valid = (arb_state == ARB_READ);

    //////////////////////////////////////////////////
    // single-port block memory
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (arb_next == ARB_WRITE)
            wave_mem[i_wr_addr] <= i_wr_data;
    end

    always_ff @(posedge ep50trig)
    begin
        if (o_rd_grant)
            o_rd_data <= wave_mem[i_rd_addr];
    end

endmodule

/* design/wave_player.sv */
`timescale 1ns/1ps

module wave_player (
    input  logic                           ep50trig,
    input  logic                           reset_global,
    input  logic                           i_sim_reset,
    input  logic                           i_tick,
    input  logic [reflex_pkg::WAVE_AW:0]   i_wave_len,
    output logic                           o_rd_req,
    output logic [reflex_pkg::WAVE_AW-1:0] o_rd_addr,
    input  logic                           i_rd_grant,
    input  logic                           i_rd_valid,
    input  logic [reflex_pkg::WAVE_DW-1:0] i_rd_data,
    output logic [reflex_pkg::WAVE_DW-1:0] o_pos,
    output logic                           o_pos_new
);
    import reflex_pkg::*;

    play_state_t      play_state;
    logic [WAVE_AW:0] addr_inc;

    // next word index, wraps to 0 at the loaded length
    assign addr_inc = {1'b0, o_rd_addr} + 1'b1;
    assign o_rd_req = (play_state == PLAY_REQ);

    // ticks seen outside PLAY_WAIT are dropped
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
        begin
            play_state <= PLAY_WAIT;
            o_rd_addr  <= '0;
            o_pos_new  <= 1'b0;
        end
        else
        begin
            o_pos_new <= 1'b0;
            case (play_state)
                PLAY_WAIT:
                    if (i_tick && (i_wave_len != '0))
                        play_state <= PLAY_REQ;
                PLAY_REQ:
                    if (i_rd_grant)
                        play_state <= PLAY_DATA;
                PLAY_DATA:
                    if (i_rd_valid)
                    begin
                        o_pos_new  <= 1'b1;
                        play_state <= PLAY_WAIT;
                        if (addr_inc >= i_wave_len)
                            o_rd_addr <= '0;
                        else
                            o_rd_addr <= addr_inc[WAVE_AW-1:0];
                    end
                default:
                    play_state <= PLAY_WAIT;
            endcase
        end
    end

    // joint position register
    always_ff @(posedge ep50trig)
    begin
        if (i_rd_valid && (play_state == PLAY_DATA))
            o_pos <= i_rd_data;
    end

endmodule

/* design/motor_neuron.sv */
`timescale 1ns/1ps

module motor_neuron (
    input  logic                           ep50trig,
    input  logic                           reset_global,
    input  logic                           i_sim_reset,
    input  logic                           i_pos_new,
    input  logic [reflex_pkg::WAVE_DW-1:0] i_pos,
    input  logic [reflex_pkg::PARAM_W-1:0] i_gain,
    input  logic [reflex_pkg::PARAM_W-1:0] i_thresh,
    input  logic [reflex_pkg::PARAM_W-1:0] i_len_ofs,
    output logic [reflex_pkg::PARAM_W-1:0] o_len,
    output logic                           o_spike
);
    import reflex_pkg::*;

    logic [PARAM_W-1:0] pos_ext;
    logic [PARAM_W-1:0] len_now;
    logic [MEM_W-1:0]   product;
    logic [MEM_W-1:0]   drive;
    logic [MEM_W-1:0]   mem_sum;
    logic               fire;
    logic [MEM_W-1:0]   membrane;

    //////////////////////////////////////////////////
    // spindle stand-in, length and drive
    //////////////////////////////////////////////////
    assign pos_ext = PARAM_W'(i_pos);

    // muscle can't be shorter than zero
    assign len_now = (i_len_ofs > pos_ext) ? (i_len_ofs - pos_ext) : '0;

    assign product = MEM_W'(len_now) * MEM_W'(i_gain);
    assign drive   = product >> GAIN_SHIFT;

    //////////////////////////////////////////////////
    // integrate and fire
    //////////////////////////////////////////////////
    assign mem_sum = membrane + drive;
    assign fire    = (mem_sum >= MEM_W'(i_thresh));

    // one spike at most per update, the residue carries over
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
        begin
            membrane <= '0;
            o_len    <= '0;
            o_spike  <= 1'b0;
        end
        else if (i_pos_new)
        begin
            o_len   <= len_now;
            o_spike <= fire;
            if (fire)
                membrane <= mem_sum - MEM_W'(i_thresh);
            else
                membrane <= mem_sum;
        end
        else
            o_spike <= 1'b0;
    end

endmodule

/* design/spike_counter.sv */
`timescale 1ns/1ps

module spike_counter (
    input  logic                         ep50trig,
    input  logic                         reset_global,
    input  logic                         i_tick,
    input  logic                         i_sim_reset,
    input  logic                         i_spike,
    output logic [reflex_pkg::CNT_W-1:0] o_count,
    output logic                         o_active
);
    import reflex_pkg::*;

    logic [ACT_W-1:0] act_left;

    // wraps around on overflow
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
            o_count <= '0;
        else if (i_spike)
            o_count <= o_count + 1'b1;
    end

    // activity stretch, a fresh spike restarts it
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_sim_reset)
            act_left <= '0;
        else if (i_spike)
            act_left <= ACT_W'(ACT_TICKS);
        else if (i_tick && (act_left != '0))
            act_left <= act_left - 1'b1;
    end

    assign o_active = (act_left != '0);

endmodule

/* design/reflex_top.sv */
`timescale 1ns/1ps

module reflex_top (
    input  logic                           ep50trig,
    input  logic [reflex_pkg::HOST_W-1:0]  i_ctrl,
    input  logic [reflex_pkg::HOST_W-1:0]  i_data_lo,
    input  logic [reflex_pkg::HOST_W-1:0]  i_data_hi,
    input  logic [reflex_pkg::HOST_W-1:0]  i_trig,
    input  logic                           i_pipe_write,
    input  logic [reflex_pkg::WAVE_DW-1:0] i_pipe_data,
    output logic                           o_tick,
    output logic [reflex_pkg::WAVE_DW-1:0] o_pos,
    output logic [reflex_pkg::PARAM_W-1:0] o_len,
    output logic                           o_spike,
    output logic [reflex_pkg::CNT_W-1:0]   o_spike_count,
    output logic                           o_active
);
    import reflex_pkg::*;

    logic               reset_global;
    logic               sim_reset;
    logic [HOST_W-1:0]  half_cnt;
    logic [PARAM_W-1:0] gain;
    logic [PARAM_W-1:0] thresh;
    logic [PARAM_W-1:0] len_ofs;
    logic               wr_req;
    logic [WAVE_AW-1:0] wr_addr;
    logic [WAVE_DW-1:0] wr_data;
    logic [WAVE_AW:0]   wave_len;
    logic               rd_req;
    logic [WAVE_AW-1:0] rd_addr;
    logic               rd_grant;
    logic               rd_valid;
    logic [WAVE_DW-1:0] rd_data;
    logic               pos_new;

    // sim reset clears the model but keeps the parameters
    assign reset_global = i_ctrl[CTRL_RESET_GLOBAL];
    assign sim_reset    = i_ctrl[CTRL_SIM_RESET];

    param_bank u_param_bank (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_trig(i_trig),
        .i_data_lo(i_data_lo), .i_data_hi(i_data_hi), .o_half_cnt(half_cnt),
        .o_gain(gain), .o_thresh(thresh), .o_len_ofs(len_ofs)
    );

    tick_gen u_tick_gen (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_reset(sim_reset),
        .i_half_cnt(half_cnt), .o_tick(o_tick)
    );

    wave_loader u_wave_loader (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_reset(sim_reset),
        .i_pipe_write(i_pipe_write), .i_pipe_data(i_pipe_data), .o_wr_req(wr_req),
        .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_wave_len(wave_len)
    );

    wave_store u_wave_store (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_wr_req(wr_req),
        .i_wr_addr(wr_addr), .i_wr_data(wr_data), .i_rd_req(rd_req), .i_rd_addr(rd_addr),
        .o_rd_grant(rd_grant), .o_rd_valid(rd_valid), .o_rd_data(rd_data)
    );

    wave_player u_wave_player (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_reset(sim_reset),
        .i_tick(o_tick), .i_wave_len(wave_len), .o_rd_req(rd_req), .o_rd_addr(rd_addr),
        .i_rd_grant(rd_grant), .i_rd_valid(rd_valid), .i_rd_data(rd_data),
        .o_pos(o_pos), .o_pos_new(pos_new)
    );

    motor_neuron u_motor_neuron (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_reset(sim_reset),
        .i_pos_new(pos_new), .i_pos(o_pos), .i_gain(gain), .i_thresh(thresh),
        .i_len_ofs(len_ofs), .o_len(o_len), .o_spike(o_spike)
    );

    spike_counter u_spike_counter (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_tick(o_tick),
        .i_sim_reset(sim_reset), .i_spike(o_spike), .o_count(o_spike_count),
        .o_active(o_active)
    );

endmodule

/* verification/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic o_clk,
    output logic o_rst
);
    // 10 ns period, reset held for the first 16 rising edges
    initial
    begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    initial
    begin
        o_rst = 1'b1;
        repeat (16) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

/* verification/tb_reflex.sv */
`timescale 1ns/1ps

module tb_reflex;

    localparam int WAVE_LEN     = 20;
    localparam int MAX_PERIOD   = 8;
    localparam int NUM_TESTS    = 6;
    localparam int WATCH_CYCLES = NUM_TESTS * WAVE_LEN * MAX_PERIOD * 4;

    logic        ep50trig;
    logic        rst;
    logic        sim_req = 1'b0;
    logic [15:0] i_ctrl = 16'h0001;
    logic [15:0] i_data_lo = '0;
    logic [15:0] i_data_hi = '0;
    logic [15:0] i_trig = '0;
    logic        i_pipe_write = 1'b0;
    logic [15:0] i_pipe_data = '0;
    logic        o_tick, o_spike, o_active;
    logic [15:0] o_pos;
    logic [31:0] o_len, o_spike_count;

    // tick periods to try, as half_cnt values
    int tick_periods [3] = '{5, 2, 7};

    // reference model state
    logic [15:0] wave_ref [0:255];
    logic [15:0] half_m;
    logic [31:0] gain_m, thr_m, ofs_m, exp_len;
    logic [31:0] cnt_exp = '0;
    logic [63:0] mem_m = '0;
    logic        exp_spike = 1'b0;
    logic        upd_q = 1'b0;
    int wr_tb = 0, wr_seen = 0, exp_idx = 0, act_left = 0;
    int cyc = 0, last_tick = 0, tick_skip = 1;
    int err_count = 0, test_err0 = 0, tests_run = 0, tests_failed = 0, stalls = 0;
    logic pos_new, in_reset;

    clk_gen u_clk_gen (.o_clk(ep50trig), .o_rst(rst));

    reflex_top i_reflex_top (
        .ep50trig(ep50trig), .i_ctrl(i_ctrl), .i_data_lo(i_data_lo), .i_data_hi(i_data_hi),
        .i_trig(i_trig), .i_pipe_write(i_pipe_write), .i_pipe_data(i_pipe_data),
        .o_tick(o_tick), .o_pos(o_pos), .o_len(o_len), .o_spike(o_spike),
        .o_spike_count(o_spike_count), .o_active(o_active)
    );

    // position strobe marks the end of a read, whatever its latency
    assign pos_new  = i_reflex_top.pos_new;
    assign in_reset = i_ctrl[0] | i_ctrl[1];

    always @(posedge ep50trig)
        i_ctrl <= {14'd0, sim_req, rst};

    always @(posedge ep50trig)
        if (i_reflex_top.rd_req && !i_reflex_top.rd_grant)
            stalls <= stalls + 1;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    always @(posedge ep50trig)
    begin : ref_model
        logic [31:0] pos_v;
        logic [31:0] len_v;
        logic [63:0] sum_v;
        cyc <= cyc + 1;
        upd_q <= 1'b0;
        if (i_ctrl[0])
        begin
            half_m <= 16'd3;
            gain_m <= 32'd256;
            thr_m  <= 32'd65536;
            ofs_m  <= 32'd40000;
        end
        if (i_trig[7]) half_m <= i_data_lo;
        if (i_trig[3]) gain_m <= {i_data_hi, i_data_lo};
        if (i_trig[4]) thr_m <= {i_data_hi, i_data_lo};
        if (i_trig[5]) ofs_m <= {i_data_hi, i_data_lo};
        if (o_tick) last_tick <= cyc;
        // a load can meet a reload, so a new period counts from the second tick
        if (in_reset)
            tick_skip <= 1;
        else if (i_trig[7])
            tick_skip <= 2;
        else if (o_tick && tick_skip != 0)
            tick_skip <= tick_skip - 1;
        if (upd_q && exp_spike)
        begin
            cnt_exp  <= cnt_exp + 32'd1;
            act_left <= 16;
        end
        else if (o_tick && act_left != 0)
            act_left <= act_left - 1;
        if (i_pipe_write) wr_seen <= wr_seen + 1;
        if (in_reset)
        begin
            wr_seen   <= 0;
            exp_idx   <= 0;
            mem_m     <= '0;
            cnt_exp   <= '0;
            act_left  <= 0;
            exp_spike <= 1'b0;
        end
        else if (pos_new)
        begin
            pos_v = {16'd0, wave_ref[exp_idx]};
            len_v = (ofs_m > pos_v) ? ofs_m - pos_v : 32'd0;
            sum_v = mem_m + (({32'd0, len_v} * {32'd0, gain_m}) >> 8);
            exp_spike <= (sum_v >= {32'd0, thr_m});
            mem_m     <= (sum_v >= {32'd0, thr_m}) ? sum_v - {32'd0, thr_m} : sum_v;
            exp_len   <= len_v;
            upd_q     <= 1'b1;
            exp_idx   <= (exp_idx + 1 >= wr_seen) ? 0 : exp_idx + 1;
        end
    end

    task automatic report_value(input string sig, input logic [63:0] exp_v,
                                input logic [63:0] got_v);
        $display("[FAIL] %0t ns %s expected %0h got %0h", $time, sig, exp_v, got_v);
        err_count++;
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    tick_period_chk: assert property (@(posedge ep50trig) disable iff (in_reset)
        (o_tick && tick_skip == 0) |-> (cyc - last_tick == int'(half_m) + 1))
        else report_value("o_tick period", 64'($sampled(half_m)) + 1,
                          64'($sampled(cyc) - $sampled(last_tick)));
    pos_chk: assert property (@(posedge ep50trig) disable iff (in_reset)
        pos_new |-> (o_pos == wave_ref[exp_idx]))
        else report_value("o_pos", 64'($sampled(wave_ref[exp_idx])), 64'($sampled(o_pos)));
    len_chk: assert property (@(posedge ep50trig) disable iff (in_reset)
        upd_q |-> (o_len == exp_len))
        else report_value("o_len", 64'($sampled(exp_len)), 64'($sampled(o_len)));
    spike_chk: assert property (@(posedge ep50trig) disable iff (in_reset)
        o_spike == (upd_q && exp_spike))
        else report_value("o_spike", 64'($sampled(upd_q && exp_spike)), 64'($sampled(o_spike)));
    count_chk: assert property (@(posedge ep50trig) disable iff (in_reset)
        o_spike_count == cnt_exp)
        else report_value("o_spike_count", 64'($sampled(cnt_exp)),
                          64'($sampled(o_spike_count)));
    active_chk: assert property (@(posedge ep50trig) disable iff (in_reset)
        o_active == (act_left != 0))
        else report_value("o_active", 64'($sampled(act_left != 0)), 64'($sampled(o_active)));

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    task automatic load_param(input int bit_idx, input logic [31:0] value);
        @(posedge ep50trig);
        i_trig    <= 16'(1 << bit_idx);
        i_data_lo <= value[15:0];
        i_data_hi <= value[31:16];
        @(posedge ep50trig);
        i_trig <= '0;
    endtask

    // back-to-back first, then gaps so reads slip between writes
    task automatic stream_words(input int n);
        logic [15:0] w;
        for (int i = 0; i < n; i++)
        begin
            w = 16'($urandom);
            wave_ref[wr_tb] = w;
            wr_tb++;
            @(posedge ep50trig);
            i_pipe_write <= 1'b1;
            i_pipe_data  <= w;
            if (i >= n / 2)
            begin
                @(posedge ep50trig);
                i_pipe_write <= 1'b0;
                repeat (int'($urandom % 4)) @(posedge ep50trig);
            end
        end
        @(posedge ep50trig);
        i_pipe_write <= 1'b0;
    endtask

    task automatic pulse_sim_reset();
        @(posedge ep50trig);
        sim_req <= 1'b1;
        repeat (2) @(posedge ep50trig);
        sim_req <= 1'b0;
        repeat (2) @(posedge ep50trig);
        wr_tb = 0;
    endtask

    task automatic wait_positions(input int n);
        repeat (n)
        begin
            do @(posedge ep50trig); while (!pos_new);
        end
    endtask

    task automatic wait_ticks(input int n);
        repeat (n)
        begin
            do @(posedge ep50trig); while (!o_tick);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count == test_err0)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     err_count - test_err0);
        end
        test_err0 = err_count;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial
    begin
        void'($urandom(32'hc306_9ba0));
        while (i_ctrl[0]) @(posedge ep50trig);
        @(negedge ep50trig);
        assert (!o_tick) else report_value("o_tick", 0, 64'(o_tick));
        assert (!o_spike) else report_value("o_spike", 0, 64'(o_spike));
        assert (!o_active) else report_value("o_active", 0, 64'(o_active));
        assert (o_spike_count == 0) else report_value("o_spike_count", 0, 64'(o_spike_count));
        end_test("after reset");

        foreach (tick_periods[k])
        begin
            load_param(7, 32'(tick_periods[k]));
            wait_ticks(5);
        end
        end_test("tick period");

        load_param(7, 32'd3);
        pulse_sim_reset();
        stream_words(WAVE_LEN);
        wait_positions(WAVE_LEN + 8);
        $display("arbiter: %0d read cycles lost to ARB_WRITE", stalls);
        if (stalls == 0)
        begin
            $display("no read was stalled by a pipe write, collision case not reached");
            err_count++;
        end
        end_test("waveform playback");

        load_param(5, 32'd30000);
        wait_positions(WAVE_LEN + 5);
        end_test("muscle length");

        load_param(3, 32'd700);
        load_param(4, 32'd50000);
        wait_positions(2 * WAVE_LEN);
        repeat (3) @(posedge ep50trig);
        if (cnt_exp == 0)
        begin
            $display("spike test produced no spikes, its checks were not reached");
            err_count++;
        end
        end_test("spikes");

        pulse_sim_reset();
        @(negedge ep50trig);
        assert (o_spike_count == 0) else report_value("o_spike_count", 0, 64'(o_spike_count));
        assert (i_reflex_top.gain == 32'd700)
            else report_value("gain", 64'd700, 64'(i_reflex_top.gain));
        stream_words(WAVE_LEN);
        wait_positions(WAVE_LEN + 5);
        end_test("simulation reset");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // each test gets four waveform passes at the longest tick period
    initial
    begin
        repeat (WATCH_CYCLES) @(posedge ep50trig);
        $display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* sim.f */
design/reflex_pkg.sv
design/param_bank.sv
design/tick_gen.sv
design/wave_loader.sv
design/wave_store.sv
design/wave_player.sv
design/motor_neuron.sv
design/spike_counter.sv
design/reflex_top.sv
verification/clk_gen.sv
verification/tb_reflex.sv

/* Makefile */
SRCS := $(wildcard design/*.sv verification/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_reflex
	@out="$$(./obj_dir/Vtb_reflex)"; echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

obj_dir/Vtb_reflex: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_reflex \
		-Mdir obj_dir -f sim.f

clean:
	rm -rf obj_dir
